/* filelist.f */
design/floppy_pkg.sv
design/fdc_control.sv
design/sector_pump.sv
design/spi_master.sv
design/sector_buffer.sv
design/floppy_top.sv
sim/floppy_properties.sv
sim/floppy_checker.sv
sim/tb_floppy.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -sv -j 0
TOP       := tb_floppy
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_floppy.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_floppy;

	import floppy_pkg::*;

	localparam int SECTOR_BYTES = 32;
	// worst case per byte is about 20 clocks of spi handshake
	localparam int CYCLE_LIMIT  = 12 * (2 + 15 + 1 + SECTOR_BYTES) * 20 + 2000;
	localparam int POLL_LIMIT   = (2 + 15 + 1 + SECTOR_BYTES) * 20;

	logic        clk;
	logic        reset_n;
	host_bus_t   host;
	logic [7:0]  host_rdata;
	logic        spi_sck;
	logic        spi_mosi;
	logic        spi_cs_n;
	logic        spi_miso;
	logic [31:0] lfsr_q;
	int          cycles = 0;
	int          next_wait;
	logic [7:0]  card_rx;
	logic [7:0]  card_track;
	logic [7:0]  card_sector;

	floppy_top #(.SECTOR_BYTES(SECTOR_BYTES)) dut0 (
		.clk         (clk),
		.reset_n     (reset_n),
		.host_i      (host),
		.host_rdata_o(host_rdata),
		.spi_sck_o   (spi_sck),
		.spi_mosi_o  (spi_mosi),
		.spi_cs_n_o  (spi_cs_n),
		.spi_miso_i  (spi_miso)
	);

	floppy_checker #(.SECTOR_BYTES(SECTOR_BYTES)) chk0 (
		.clk         (clk),
		.reset_n     (reset_n),
		.host_i      (host),
		.host_rdata_i(host_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// hard stop
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// random numbers
	//////////////////////////////////////////////////////////////////////

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// sd card model
	//////////////////////////////////////////////////////////////////////

	// reply stream: header filler, wait bytes, token, data
	function automatic logic [7:0] card_reply(input int idx, input int w,
			input logic [7:0] t, input logic [7:0] s);
		int v;
		if (idx < 2 + w)
			return IDLE_BYTE;
		if (idx == 2 + w)
			return DATA_TOKEN;
		v = 3 * int'(t) + int'(s) + (idx - 3 - w);
		return v[7:0];
	endfunction

	// mosi is stable on rising sck
	always @(posedge spi_sck) begin
		if (!spi_cs_n)
			card_rx = {card_rx[6:0], spi_mosi};
	end

	initial begin
		int         wait_bytes;
		int         byte_idx;
		int         bit_idx;
		logic [7:0] tx;
		spi_miso    = 1'b1;
		card_track  = '0;
		card_sector = '0;
		forever begin
			@(negedge spi_cs_n);
			wait_bytes = next_wait;
			byte_idx   = 0;
			bit_idx    = 0;
			tx         = card_reply(0, wait_bytes, card_track, card_sector);
			// msb ready before the first rising sck
			spi_miso   = tx[7];
			while (!spi_cs_n) begin
				@(negedge spi_sck or posedge spi_cs_n);
				if (!spi_cs_n) begin
					bit_idx = bit_idx + 1;
					if (bit_idx == 8) begin
						// header must carry the registers latched by the command
						if (byte_idx == 0) begin
							card_track = card_rx;
							chk0.compare("spi_mosi_o (track byte)", chk0.sel_track,
								card_rx);
						end else if (byte_idx == 1) begin
							card_sector = card_rx;
							chk0.compare("spi_mosi_o (sector byte)", chk0.sel_sector,
								card_rx);
						end
						byte_idx = byte_idx + 1;
						bit_idx  = 0;
						tx = card_reply(byte_idx, wait_bytes, card_track, card_sector);
					end
					spi_miso = tx[7 - bit_idx];
				end
			end
			spi_miso = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// host bus
	//////////////////////////////////////////////////////////////////////

	task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
		@(posedge clk);
		host <= '{addr: addr, wr: 1'b1, rd: 1'b0, wdata: data};
		@(posedge clk);
		host <= '0;
	endtask

	// value is valid from the cycle after the strobe
	task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
		@(posedge clk);
		host <= '{addr: addr, wr: 1'b0, rd: 1'b1, wdata: 8'h00};
		@(posedge clk);
		host <= '0;
		@(negedge clk);
		data = host_rdata;
	endtask

	task automatic host_write(input fdc_reg_e reg_id, input logic [7:0] data);
		bus_write({1'b0, reg_id}, data);
	endtask

	task automatic host_read(input fdc_reg_e reg_id, output logic [7:0] data);
		bus_read({1'b0, reg_id}, data);
	endtask

	task automatic random_gap();
		logic [31:0] r;
		take_bits(2, r);
		repeat (int'(r[1:0])) @(posedge clk);
	endtask

	// load registers and fire a read-sector
	task automatic start_read(input logic [7:0] t, input logic [7:0] s);
		logic [31:0] r;
		logic [7:0]  st;
		take_bits(4, r);
		next_wait = int'(r[3:0]);
		host_write(REG_TRACK, t);
		host_write(REG_SECTOR, s);
		random_gap();
		host_write(REG_CMDSTAT, CMD_READ_SECTOR);
		host_read(REG_CMDSTAT, st);
	endtask

	task automatic wait_drq();
		logic [7:0] st;
		int         polls;
		polls = 0;
		st    = 8'h00;
		while (!st[1] && polls < POLL_LIMIT) begin
			host_read(REG_CMDSTAT, st);
			polls = polls + 1;
		end
		if (!st[1])
			chk0.note_failure("data request never came up after a read-sector command");
	endtask

	task automatic drain(input int n);
		logic [7:0] d;
		for (int i = 0; i < n; i++)
			host_read(REG_DATA, d);
	endtask

	task automatic fetch_sector(input logic [7:0] t, input logic [7:0] s);
		logic [7:0] st;
		start_read(t, s);
		wait_drq();
		drain(SECTOR_BYTES);
		host_read(REG_CMDSTAT, st);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [7:0]  d;
		logic [7:0]  t;
		logic [7:0]  s;
		host      = '0;
		reset_n   = 1'b0;
		next_wait = 0;
		lfsr_q    = 32'd78700;
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);

		host_read(REG_TRACK, d);
		host_read(REG_SECTOR, d);
		host_read(REG_CMDSTAT, d);
		// card deselected and clock parked low
		chk0.compare("spi_cs_n_o", 8'h01, {7'b0, spi_cs_n});
		chk0.compare("spi_sck_o", 8'h00, {7'b0, spi_sck});
		chk0.end_test("reset values");

		take_bits(8, r);
		t = r[7:0];
		host_write(REG_TRACK, t);
		take_bits(8, r);
		host_write(REG_SECTOR, r[7:0]);
		host_read(REG_TRACK, d);
		host_read(REG_SECTOR, d);
		// upper address bit set, no register answers
		bus_write(3'b110, ~t);
		bus_read(3'b111, d);
		host_read(REG_TRACK, d);
		// not a read-sector code
		host_write(REG_CMDSTAT, 8'h13);
		host_read(REG_CMDSTAT, d);
		host_read(REG_DATA, d);
		chk0.end_test("register readback");

		take_bits(8, r);
		t = r[7:0];
		take_bits(8, r);
		s = r[7:0];
		fetch_sector(t, s);
		chk0.end_test("single sector");

		for (int n = 0; n < 10; n++) begin
			take_bits(8, r);
			t = r[7:0];
			take_bits(8, r);
			s = r[7:0];
			fetch_sector(t, s);
		end
		chk0.end_test("ten random sectors");

		// second command lands while the first is still fetching
		start_read(8'h21, 8'h05);
		host_write(REG_TRACK, 8'h44);
		host_write(REG_SECTOR, 8'h09);
		host_write(REG_CMDSTAT, CMD_READ_SECTOR);
		wait_drq();
		drain(SECTOR_BYTES);
		host_read(REG_CMDSTAT, d);
		chk0.end_test("command while busy");

		// restart half way through the drain
		start_read(8'h10, 8'h02);
		wait_drq();
		drain(SECTOR_BYTES / 2);
		start_read(8'h37, 8'h0c);
		wait_drq();
		drain(SECTOR_BYTES);
		host_read(REG_CMDSTAT, d);
		chk0.end_test("restart during drain");

		chk0.report();
		if (chk0.error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/floppy_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module floppy_checker #(
	parameter int SECTOR_BYTES = 32
) (
	input wire                   clk,
	input wire                   reset_n,
	input floppy_pkg::host_bus_t host_i,
	input wire  [7:0]            host_rdata_i
);

	import floppy_pkg::*;

	typedef enum {M_IDLE, M_BUSY, M_DRAIN} mode_e;

	host_bus_t  seen;
	mode_e      mode;
	logic [7:0] track_m;
	logic [7:0] sector_m;
	logic [7:0] sel_track;
	logic [7:0] sel_sector;
	logic       busy_seen;
	int         ptr;
	int         error_count = 0;
	int         check_count = 0;
	int         test_count  = 0;
	int         test_errors = 0;

	// card rule for byte i of (t, s)
	function automatic logic [7:0] expected_byte(input logic [7:0] t, input logic [7:0] s,
			input int i);
		int v;
		v = 3 * int'(t) + int'(s) + i;
		return v[7:0];
	endfunction

	task automatic compare(input string what, input logic [7:0] exp, input logic [7:0] got);
		check_count = check_count + 1;
		if (exp !== got) begin
			$display("[ERROR] %0t %s: expected %02h, got %02h", $time, what, exp, got);
			error_count = error_count + 1;
			test_errors = test_errors + 1;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("failure at %0t: %s", $time, msg);
		error_count = error_count + 1;
		test_errors = test_errors + 1;
	endtask

	task automatic end_test(input string name);
		test_count = test_count + 1;
		if (test_errors == 0)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: %0d errors", test_count, name, test_errors);
		test_errors = 0;
	endtask

	task automatic report();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
	endtask

	// what the dut sampled on this edge
	always @(posedge clk) begin
		seen <= host_i;
	end

	//////////////////////////////////////////////////////////////////////
	// register model, evaluated mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset_n) begin
			mode      = M_IDLE;
			track_m   = '0;
			sector_m  = '0;
			busy_seen = 1'b0;
			ptr       = 0;
		end else if (seen.wr && !seen.addr[2]) begin
			case (fdc_reg_e'(seen.addr[1:0]))
			REG_TRACK:  track_m = seen.wdata;
			REG_SECTOR: sector_m = seen.wdata;
			REG_CMDSTAT: begin
				// accepted from idle or drain only
				if (seen.wdata == CMD_READ_SECTOR && mode != M_BUSY) begin
					mode       = M_BUSY;
					busy_seen  = 1'b0;
					sel_track  = track_m;
					sel_sector = sector_m;
					ptr        = 0;
				end
			end
			default: ;
			endcase
		end else if (seen.rd) begin
			if (seen.addr[2])
				compare("host_rdata_o (unmapped)", 8'h00, host_rdata_i);
			else begin
				case (fdc_reg_e'(seen.addr[1:0]))
				REG_TRACK:  compare("host_rdata_o (track)", track_m, host_rdata_i);
				REG_SECTOR: compare("host_rdata_o (sector)", sector_m, host_rdata_i);
				REG_CMDSTAT: begin
					// busy shows first, then drq may show up on any later poll
					if (mode == M_BUSY && busy_seen && host_rdata_i == 8'h02) begin
						check_count = check_count + 1;
						mode        = M_DRAIN;
					end else if (mode == M_BUSY) begin
						compare("host_rdata_o (status)", 8'h01, host_rdata_i);
						busy_seen = 1'b1;
					end else if (mode == M_DRAIN)
						compare("host_rdata_o (status)", 8'h02, host_rdata_i);
					else
						compare("host_rdata_o (status)", 8'h00, host_rdata_i);
				end
				default: begin
					if (mode == M_DRAIN) begin
						compare($sformatf("host_rdata_o (data byte %0d)", ptr),
							expected_byte(sel_track, sel_sector, ptr), host_rdata_i);
						ptr = ptr + 1;
						if (ptr == SECTOR_BYTES)
							mode = M_IDLE;
					end else
						compare("host_rdata_o (data, no drq)", 8'h00, host_rdata_i);
				end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* sim/floppy_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module floppy_properties (
	input wire clk,
	input wire reset_n,
	input wire pump_req,
	input wire pump_ack,
	input wire spi_req,
	input wire spi_ack,
	input wire cs_n,
	input wire drq
);

	//////////////////////////////////////////////////////////////////////
	// four-phase handshakes
	//////////////////////////////////////////////////////////////////////

	a_pump_ack_rise: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(pump_ack) |-> pump_req) else $error("pump_ack rose without pump_req");

	a_pump_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
		pump_req && !pump_ack |=> pump_req) else $error("pump_req dropped before ack");

	a_spi_ack_rise: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(spi_ack) |-> spi_req) else $error("spi_ack rose without spi_req");

	a_spi_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
		spi_req && !spi_ack |=> spi_req) else $error("spi_req dropped before ack");

	// sector offered to the host only once the pump has closed and released the card
	a_drq_after_fetch: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(drq) |-> !pump_ack && cs_n) else $error("drq rose before the fetch closed");

	// card selected for the whole fetch, pump takes one clock to react
	a_cs_low: assert property (@(posedge clk) disable iff (!reset_n)
		pump_req && $past(pump_req) && !pump_ack |-> !cs_n)
		else $error("cs_n high during a sector fetch");

endmodule

bind floppy_top floppy_properties props0 (
	.clk     (clk),
	.reset_n (reset_n),
	.pump_req(pump_req),
	.pump_ack(pump_ack),
	.spi_req (spi_req),
	.spi_ack (spi_ack),
	.cs_n    (spi_cs_n_o),
	.drq     (ctrl0.status.drq)
);

`default_nettype wire

/* design/floppy_top.sv */
`timescale 1ns/1ps
`default_nettype none

module floppy_top #(
	parameter int SECTOR_BYTES = 32
) (
	input  wire                   clk,
	input  wire                   reset_n,
	input  floppy_pkg::host_bus_t host_i,
	output logic [7:0]            host_rdata_o,
	output logic                  spi_sck_o,
	output logic                  spi_mosi_o,
	output logic                  spi_cs_n_o,
	input  wire                   spi_miso_i
);

	import floppy_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// interconnect
	//////////////////////////////////////////////////////////////////////

	// controller to pump
	logic        pump_req;
	logic        pump_ack;
	sector_req_t pump_sel;
	// controller to buffer
	logic [7:0]  rd_addr;
	logic [7:0]  rd_data;
	// pump to spi
	logic        spi_req;
	logic        spi_ack;
	logic [7:0]  spi_tx;
	logic [7:0]  spi_rx;
	// pump to buffer
	buf_wr_t     buf_wr;

	fdc_control #(.SECTOR_BYTES(SECTOR_BYTES)) ctrl0 (
		.clk         (clk),
		.reset_n     (reset_n),
		.host_i      (host_i),
		.host_rdata_o(host_rdata_o),
		.pump_req_o  (pump_req),
		.pump_sel_o  (pump_sel),
		.pump_ack_i  (pump_ack),
		.rd_addr_o   (rd_addr),
		.rd_data_i   (rd_data)
	);

	sector_pump #(.SECTOR_BYTES(SECTOR_BYTES)) pump0 (
		.clk       (clk),
		.reset_n   (reset_n),
		.pump_req_i(pump_req),
		.pump_sel_i(pump_sel),
		.pump_ack_o(pump_ack),
		.spi_req_o (spi_req),
		.spi_tx_o  (spi_tx),
		.spi_ack_i (spi_ack),
		.spi_rx_i  (spi_rx),
		.spi_cs_n_o(spi_cs_n_o),
		.buf_wr_o  (buf_wr)
	);

	spi_master spi0 (
		.clk      (clk),
		.reset_n  (reset_n),
		.spi_req_i(spi_req),
		.spi_tx_i (spi_tx),
		.spi_ack_o(spi_ack),
		.spi_rx_o (spi_rx),
		.sck_o    (spi_sck_o),
		.mosi_o   (spi_mosi_o),
		.miso_i   (spi_miso_i)
	);

	sector_buffer #(.SECTOR_BYTES(SECTOR_BYTES)) buf0 (
		.clk      (clk),
		.buf_wr_i (buf_wr),
		.rd_addr_i(rd_addr),
		.rd_data_o(rd_data)
	);

endmodule

`default_nettype wire

/* design/sector_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module sector_buffer #(
	parameter int SECTOR_BYTES = 32
) (
	input  wire                 clk,
	input  floppy_pkg::buf_wr_t buf_wr_i,
	input  wire  [7:0]          rd_addr_i,
	output logic [7:0]          rd_data_o
);

	// index width follows the sector size
	localparam int AW = (SECTOR_BYTES > 1) ? $clog2(SECTOR_BYTES) : 1;

	logic [7:0] mem [SECTOR_BYTES];

	// one write port from the pump
	always_ff @(posedge clk) begin
		if (buf_wr_i.we)
			mem[buf_wr_i.addr[AW-1:0]] <= buf_wr_i.data;
	end

	// registered read, one cycle latency
	always_ff @(posedge clk) begin
		rd_data_o <= mem[rd_addr_i[AW-1:0]];
	end

endmodule

`default_nettype wire

/* design/spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master (
	input  wire        clk,
	input  wire        reset_n,
	input  wire        spi_req_i,
	input  wire  [7:0] spi_tx_i,
	output logic       spi_ack_o,
	output logic [7:0] spi_rx_o,
	output logic       sck_o,
	output logic       mosi_o,
	input  wire        miso_i
);

	logic       busy_q;
	logic [3:0] half_q;
	logic [7:0] tx_sh;
	logic [7:0] rx_sh;
	logic       start;
	logic       rise;
	logic       fall;

	// new byte only once the previous ack has been taken back
	assign start = spi_req_i && !busy_q && !spi_ack_o;
	// sck edges happen on the clk edge that flips sck_o
	assign rise  = busy_q && !sck_o;
	assign fall  = busy_q && sck_o;

	//////////////////////////////////////////////////////////////////////
	// sck, bit count and ack
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy_q    <= 1'b0;
			half_q    <= '0;
			sck_o     <= 1'b0;
			mosi_o    <= 1'b1;
			spi_ack_o <= 1'b0;
		end else if (busy_q) begin
			sck_o  <= ~sck_o;
			half_q <= half_q + 4'd1;
			if (fall) begin
				// next bit goes out while sck drops
				mosi_o <= tx_sh[6];
				// 16th half period ends the byte
				if (half_q == 4'd15) begin
					busy_q    <= 1'b0;
					spi_ack_o <= 1'b1;
				end
			end
		end else if (spi_ack_o) begin
			if (!spi_req_i)
				spi_ack_o <= 1'b0;
		end else if (start) begin
			// msb must be on the line before the first rising edge
			busy_q <= 1'b1;
			half_q <= '0;
			mosi_o <= spi_tx_i[7];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// shift registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start)
			tx_sh <= spi_tx_i;
		else if (fall)
			tx_sh <= {tx_sh[6:0], 1'b1};
		// sample on rising sck
		if (rise)
			rx_sh <= {rx_sh[6:0], miso_i};
	end

	// rx is complete before ack and frozen until the next start
	assign spi_rx_o = rx_sh;

endmodule

`default_nettype wire

/* design/sector_pump.sv */
`timescale 1ns/1ps
`default_nettype none

module sector_pump #(
	parameter int SECTOR_BYTES = 32
) (
	input  wire                     clk,
	input  wire                     reset_n,
	input  wire                     pump_req_i,
	input  floppy_pkg::sector_req_t pump_sel_i,
	output logic                    pump_ack_o,
	output logic                    spi_req_o,
	output logic [7:0]              spi_tx_o,
	input  wire                     spi_ack_i,
	input  wire  [7:0]              spi_rx_i,
	output logic                    spi_cs_n_o,
	output floppy_pkg::buf_wr_t     buf_wr_o
);

	import floppy_pkg::*;

	localparam logic [7:0] LAST_BYTE = 8'(SECTOR_BYTES - 1);

	// handshake with the spi master
	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_REL, ST_DONE} state_e;
	// what the current byte means
	typedef enum logic [1:0] {PH_TRACK, PH_SECTOR, PH_HUNT, PH_DATA} phase_e;

	state_e     state_q;
	phase_e     phase_q;
	logic [7:0] cnt_q;
	logic       last_q;
	logic       wr_en_q;
	logic [7:0] wr_data_q;
	logic [7:0] wr_addr_q;
	logic       byte_in;
	logic       take_byte;

	assign byte_in   = (state_q == ST_REQ) && spi_ack_i;
	assign take_byte = byte_in && (phase_q == PH_DATA);

	// header bytes first, idle fill after
	always_comb begin
		case (phase_q)
		PH_TRACK:  spi_tx_o = pump_sel_i.track;
		PH_SECTOR: spi_tx_o = pump_sel_i.sector;
		default:   spi_tx_o = IDLE_BYTE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state_q    <= ST_IDLE;
			phase_q    <= PH_TRACK;
			cnt_q      <= '0;
			last_q     <= 1'b0;
			spi_req_o  <= 1'b0;
			spi_cs_n_o <= 1'b1;
			pump_ack_o <= 1'b0;
			wr_en_q    <= 1'b0;
		end else begin
			wr_en_q <= take_byte;
			case (state_q)
			ST_IDLE: begin
				if (pump_req_i) begin
					spi_cs_n_o <= 1'b0;
					phase_q    <= PH_TRACK;
					cnt_q      <= '0;
					last_q     <= 1'b0;
					spi_req_o  <= 1'b1;
					state_q    <= ST_REQ;
				end
			end
			ST_REQ: begin
				if (spi_ack_i) begin
					spi_req_o <= 1'b0;
					state_q   <= ST_REL;
					case (phase_q)
					PH_TRACK:  phase_q <= PH_SECTOR;
					PH_SECTOR: phase_q <= PH_HUNT;
					// keep clocking 0xff until the card answers
					PH_HUNT: begin
						if (spi_rx_i == DATA_TOKEN)
							phase_q <= PH_DATA;
					end
					default: begin
						cnt_q <= cnt_q + 8'd1;
						if (cnt_q == LAST_BYTE)
							last_q <= 1'b1;
					end
					endcase
				end
			end
			// ack must fall before the next byte
			ST_REL: begin
				if (!spi_ack_i) begin
					if (last_q) begin
						spi_cs_n_o <= 1'b1;
						pump_ack_o <= 1'b1;
						state_q    <= ST_DONE;
					end else begin
						spi_req_o <= 1'b1;
						state_q   <= ST_REQ;
					end
				end
			end
			default: begin
				if (!pump_req_i) begin
					pump_ack_o <= 1'b0;
					state_q    <= ST_IDLE;
				end
			end
			endcase
		end
	end

	// byte and address ride along with the write enable
	always_ff @(posedge clk) begin
		if (take_byte) begin
			wr_data_q <= spi_rx_i;
			wr_addr_q <= cnt_q;
		end
	end

	assign buf_wr_o = '{we: wr_en_q, data: wr_data_q, addr: wr_addr_q};

endmodule

`default_nettype wire

/* design/fdc_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_control #(
	parameter int SECTOR_BYTES = 32
) (
	input  wire                     clk,
	input  wire                     reset_n,
	input  floppy_pkg::host_bus_t   host_i,
	output logic [7:0]              host_rdata_o,
	output logic                    pump_req_o,
	output floppy_pkg::sector_req_t pump_sel_o,
	input  wire                     pump_ack_i,
	output logic [7:0]              rd_addr_o,
	input  wire  [7:0]              rd_data_i
);

	import floppy_pkg::*;

	localparam logic [7:0] LAST_BYTE = 8'(SECTOR_BYTES - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_ACK_LOW,
		ST_DRAIN
	} state_e;

	state_e      state_q;
	logic [7:0]  track_q;
	logic [7:0]  sector_q;
	logic [7:0]  ptr_q;
	logic [7:0]  ptr_d;
	sector_req_t sel_q;
	fdc_status_t status;
	fdc_reg_e    reg_sel;
	logic        hit;
	logic        cmd_wr;
	logic        start;
	logic        data_rd;

	//////////////////////////////////////////////////////////////////////
	// host decode
	//////////////////////////////////////////////////////////////////////

	// upper address bit must be clear
	assign hit     = (host_i.addr[2] == 1'b0);
	assign reg_sel = fdc_reg_e'(host_i.addr[1:0]);

	assign cmd_wr  = host_i.wr && hit && (reg_sel == REG_CMDSTAT) &&
			(host_i.wdata == CMD_READ_SECTOR);
	// busy swallows commands, drain gets restarted
	assign start   = cmd_wr && !status.busy;
	assign data_rd = host_i.rd && hit && (reg_sel == REG_DATA) && (state_q == ST_DRAIN);

	always_comb begin
		status      = '0;
		status.busy = (state_q == ST_FETCH) || (state_q == ST_ACK_LOW);
		status.drq  = (state_q == ST_DRAIN);
	end

	//////////////////////////////////////////////////////////////////////
	// command fsm
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state_q  <= ST_IDLE;
			track_q  <= '0;
			sector_q <= '0;
		end else begin
			if (host_i.wr && hit && reg_sel == REG_TRACK)
				track_q <= host_i.wdata;
			if (host_i.wr && hit && reg_sel == REG_SECTOR)
				sector_q <= host_i.wdata;

			case (state_q)
			ST_IDLE: begin
				if (start)
					state_q <= ST_FETCH;
			end
			// pump owns the card until ack
			ST_FETCH: begin
				if (pump_ack_i)
					state_q <= ST_ACK_LOW;
			end
			ST_ACK_LOW: begin
				if (!pump_ack_i)
					state_q <= ST_DRAIN;
			end
			ST_DRAIN: begin
				if (start)
					state_q <= ST_FETCH;
				else if (data_rd && ptr_q == LAST_BYTE)
					state_q <= ST_IDLE;
			end
			default: state_q <= ST_IDLE;
			endcase
		end
	end

	// snapshot of track/sector for the whole fetch
	always_ff @(posedge clk) begin
		if (start)
			sel_q <= '{track: track_q, sector: sector_q};
	end

	assign pump_req_o = (state_q == ST_FETCH);
	assign pump_sel_o = sel_q;

	//////////////////////////////////////////////////////////////////////
	// read pointer and host data
	//////////////////////////////////////////////////////////////////////

	// buffer sees the next pointer, so its byte is ready one cycle later
	always_comb begin
		ptr_d = ptr_q;
		if (start)
			ptr_d = '0;
		else if (data_rd)
			ptr_d = ptr_q + 8'd1;
	end

	assign rd_addr_o = ptr_d;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ptr_q        <= '0;
			host_rdata_o <= '0;
		end else begin
			ptr_q <= ptr_d;
			// read data holds until the next strobe
			if (host_i.rd) begin
				if (!hit)
					host_rdata_o <= '0;
				else begin
					case (reg_sel)
					REG_DATA:    host_rdata_o <= data_rd ? rd_data_i : 8'h00;
					REG_SECTOR:  host_rdata_o <= sector_q;
					REG_TRACK:   host_rdata_o <= track_q;
					REG_CMDSTAT: host_rdata_o <= status;
					default:     host_rdata_o <= '0;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/floppy_pkg.sv */
`default_nettype none

package floppy_pkg;

	// host register window, low two bits of the host address
	typedef enum logic [1:0] {
		REG_DATA    = 2'd0,
		REG_SECTOR  = 2'd1,
		REG_TRACK   = 2'd2,
		REG_CMDSTAT = 2'd3
	} fdc_reg_e;

	// only read-sector is decoded, everything else falls on the floor
	localparam logic [7:0] CMD_READ_SECTOR = 8'h80;

	// card side byte values
	localparam logic [7:0] DATA_TOKEN = 8'hFE;
	localparam logic [7:0] IDLE_BYTE  = 8'hFF;

	// one host bus cycle, strobes are single clock
	typedef struct packed {
		logic [2:0] addr;
		logic       wr;
		logic       rd;
		logic [7:0] wdata;
	} host_bus_t;

	// status byte as seen at REG_CMDSTAT
	typedef struct packed {
		logic [5:0] rsvd;
		logic       drq;
		logic       busy;
	} fdc_status_t;

	// which sector to fetch
	typedef struct packed {
		logic [7:0] track;
		logic [7:0] sector;
	} sector_req_t;

	// buffer write port, 8-bit address caps the sector at 256 bytes
	typedef struct packed {
		logic       we;
		logic [7:0] data;
		logic [7:0] addr;
	} buf_wr_t;

endpackage

`default_nettype wire
